// ==== src/fdc_pkg.sv ====
package fdc_pkg;

	localparam int MAX_DRIVES = 4;
	localparam int DRV_W      = $clog2(MAX_DRIVES); // drive number width

	// host register map
	typedef enum logic [2:0] {
		A_CMD    = 3'b000, // command on write, status on read
		A_TRACK  = 3'b001,
		A_SECTOR = 3'b010,
		A_DATA   = 3'b011,
		A_CTL2   = 3'b111  // side and drive select
	} fdc_addr_e;

	// --------------------------------------------------
	// workhorse link

	typedef enum logic [1:0] {
		REQ_ACK       = 2'd0, // nothing pending
		REQ_NOP       = 2'd1, // type I, just a delay
		REQ_READ      = 2'd2,
		REQ_READ_ADDR = 2'd3
	} req_kind_e;

	typedef struct packed {
		req_kind_e        kind;
		logic             side;
		logic [DRV_W-1:0] drive;
		logic [7:0]       sector;
	} wh_req_t;

	// --------------------------------------------------
	// internal commands

	typedef enum logic [1:0] {
		HEAD_RESTORE,
		HEAD_SEEK,
		HEAD_STEP
	} head_op_e;

	typedef struct packed {
		logic             valid;     // one cycle pulse
		logic [DRV_W-1:0] drive;
		head_op_e         op;
		logic             step_out;  // 1 = towards track 0
		logic [7:0]       target;    // seek destination
		logic             head_load;
	} head_cmd_t;

	typedef enum logic [1:0] {
		XFER_NOP_WAIT,
		XFER_READ,
		XFER_READ_ADDR,
		XFER_ABORT
	} xfer_op_e;

	typedef struct packed {
		logic             valid;
		xfer_op_e         op;
		logic             multi;  // run to end of track
		logic             side;
		logic [DRV_W-1:0] drive;
		logic [7:0]       sector;
	} xfer_cmd_t;

	// --------------------------------------------------
	// state and status

	typedef struct packed {
		logic [7:0] track;
		logic       track0;
		logic       head_loaded;
		logic       index;
	} drive_state_t;

	typedef struct packed {
		logic busy;
		logic drq;
		logic lost_data;
		logic seek_err;  // also record not found
		logic irq;
	} xfer_flags_t;

	typedef struct packed {
		logic not_ready;
		logic read_only;
		logic head_loaded;
		logic seek_err;
		logic crc_err;
		logic track0;
		logic index;
		logic busy;
	} status_t1_t;

	typedef struct packed {
		logic not_ready;
		logic read_only;
		logic write_fault;
		logic seek_err;
		logic crc_err;
		logic lost_data;
		logic drq;
		logic busy;
	} status_t2_t;

	// same status byte, layout picked by last command type
	typedef union packed {
		status_t1_t t1;
		status_t2_t t2;
	} fdc_status_u;

endpackage

// ==== src/fdc_host_regs.sv ====
module fdc_host_regs import fdc_pkg::*; (
	input  logic             clk,
	input  logic             cock,
	input  logic             rd,
	input  logic             wr,
	input  fdc_addr_e        addr,
	input  logic [7:0]       idata,
	input  xfer_flags_t      xfer_flags,
	input  logic [7:0]       sel_track,   // head of the selected drive
	input  logic [7:0]       next_sector, // multi-sector advance
	input  logic             sector_load,
	output head_cmd_t        head_cmd,
	output xfer_cmd_t        xfer_cmd,
	output logic             data_rd,
	output logic [7:0]       track_reg,
	output logic [7:0]       sector_reg,
	output logic             side,
	output logic [DRV_W-1:0] drive,
	output logic             cmd_mode,    // 0 type I status, 1 type II/III
	output fdc_addr_e        rd_sel,
	output logic [7:0]       data_wr_val
);

	// upper command nibbles
	localparam logic [3:0] C_RESTORE   = 4'h0;
	localparam logic [3:0] C_SEEK      = 4'h1;
	localparam logic [3:0] C_READ_ADDR = 4'hc;
	localparam logic [3:0] C_FORCE_INT = 4'hd;

	logic       step_dir;   // remembered for plain step
	logic       new_dir;
	logic       held;       // busy, or a command just issued
	logic       cmd_wr;
	logic [3:0] nib;
	logic [1:0] upd_stage;  // step with update, waits for the drive

	assign nib     = idata[7:4];
	assign held    = xfer_flags.busy || xfer_cmd.valid;
	assign cmd_wr  = wr && addr == A_CMD;
	assign new_dir = idata[6] ? idata[5] : step_dir;
	assign data_rd = rd && addr == A_DATA; // drq clears at this edge

	always_ff @(posedge clk or posedge cock) begin
		if (cock) begin
			head_cmd   <= '0;
			xfer_cmd   <= '0;
			track_reg  <= 8'd0;
			sector_reg <= 8'd0;
			side       <= 1'b0;
			drive      <= '0;
			cmd_mode   <= 1'b0;
			step_dir   <= 1'b0;
			upd_stage  <= 2'b00;
			rd_sel     <= A_CMD;
		end else begin
			head_cmd.valid <= 1'b0;
			xfer_cmd.valid <= 1'b0;
			upd_stage      <= {upd_stage[0], 1'b0};
			if (rd)
				rd_sel <= addr;
			if (sector_load)
				sector_reg <= next_sector;
			if (upd_stage[1])
				track_reg <= sel_track; // drive moved last cycle

			if (wr) begin
				case (addr)
				A_TRACK:  if (!held) track_reg <= idata;
				A_SECTOR: if (!held) sector_reg <= idata;
				A_CTL2: begin
					side  <= idata[2];
					drive <= idata[DRV_W-1:0];
				end
				default: ;
				endcase
			end

			// --------------------------------------------------
			// command decode
			if (cmd_wr && nib == C_FORCE_INT) begin
				xfer_cmd.valid <= 1'b1; // taken even while busy
				xfer_cmd.op    <= XFER_ABORT;
				cmd_mode       <= 1'b0;
			end else if (cmd_wr && !held) begin
				xfer_cmd.side      <= side;
				xfer_cmd.drive     <= drive;
				xfer_cmd.sector    <= sector_reg;
				xfer_cmd.multi     <= 1'b0;
				head_cmd.drive     <= drive;
				head_cmd.head_load <= idata[3];
				head_cmd.target    <= data_wr_val;
				head_cmd.step_out  <= new_dir;
				if (!idata[7]) begin
					// type I, head move plus a workhorse delay
					head_cmd.valid <= 1'b1;
					xfer_cmd.valid <= 1'b1;
					xfer_cmd.op    <= XFER_NOP_WAIT;
					cmd_mode       <= 1'b0;
					if (nib == C_RESTORE) begin
						head_cmd.op <= HEAD_RESTORE;
						track_reg   <= 8'd0;
					end else if (nib == C_SEEK) begin
						head_cmd.op <= HEAD_SEEK;
						track_reg   <= data_wr_val;
					end else begin
						head_cmd.op <= HEAD_STEP;
						if (idata[6])
							step_dir <= idata[5];
						if (idata[4])
							upd_stage[0] <= 1'b1;
					end
				end else if (nib[3:1] == 3'b100) begin
					xfer_cmd.valid <= 1'b1; // read sector
					xfer_cmd.op    <= XFER_READ;
					xfer_cmd.multi <= idata[4];
					cmd_mode       <= 1'b1;
				end else if (nib == C_READ_ADDR) begin
					xfer_cmd.valid <= 1'b1;
					xfer_cmd.op    <= XFER_READ_ADDR;
					cmd_mode       <= 1'b1;
				end
				// write sector, read and write track fall through
			end
		end
	end

	// data register, also the seek target
	always_ff @(posedge clk) begin
		if (wr && addr == A_DATA)
			data_wr_val <= idata;
	end

	a_no_cmd_busy: assert property (@(posedge clk) disable iff (cock)
		(head_cmd.valid || (xfer_cmd.valid && xfer_cmd.op != XFER_ABORT))
			|-> !xfer_flags.busy);

endmodule

// ==== src/fdc_drive_head.sv ====
module fdc_drive_head import fdc_pkg::*; #(
	parameter int DRIVE_ID = 0
) (
	input  logic         clk,
	input  logic         cock,
	input  head_cmd_t    head_cmd,
	output drive_state_t state
);

	logic       hit;        // command meant for this drive
	logic [7:0] next_track;

	assign hit = head_cmd.valid && head_cmd.drive == DRV_W'(DRIVE_ID);

	always_comb begin
		case (head_cmd.op)
		HEAD_RESTORE: next_track = 8'd0;
		HEAD_SEEK:    next_track = head_cmd.target;
		default:      next_track = head_cmd.step_out ? state.track - 8'd1
		                                             : state.track + 8'd1; // wraps
		endcase
	end

	always_ff @(posedge clk or posedge cock) begin
		if (cock) begin
			state.track       <= 8'hff; // unknown until restore
			state.track0      <= 1'b0;
			state.head_loaded <= 1'b0;
			state.index       <= 1'b0;
		end else if (hit) begin
			state.track       <= next_track;
			state.track0      <= next_track == 8'd0;
			state.head_loaded <= head_cmd.head_load;
			state.index       <= 1'b1; // no media, index faked
		end
	end

	a_track0: assert property (@(posedge clk) disable iff (cock)
		state.track0 == (state.track == 8'd0));

endmodule

// ==== src/fdc_transfer.sv ====
module fdc_transfer import fdc_pkg::*; #(
	parameter int SECTOR_BYTES      = 1024,
	parameter int SECTORS_PER_TRACK = 5,
	parameter int FETCH_DELAY       = 15,
	parameter int LOST_TIMEOUT      = 255,
	localparam int AW = $clog2(SECTOR_BYTES)
) (
	input  logic          clk,
	input  logic          cock,
	input  xfer_cmd_t     xfer_cmd,
	input  logic          data_rd,
	input  logic          wh_done,
	input  logic          wh_ok,
	input  logic [7:0]    buff_idata,
	output wh_req_t       wh_req,
	output logic [AW-1:0] buff_addr,
	output logic          buff_rd,
	output logic [7:0]    data_reg,
	output xfer_flags_t   flags,
	output logic [7:0]    next_sector,
	output logic          sector_load
);

	localparam int CW = $clog2(SECTOR_BYTES + 1);
	localparam int TW = $clog2(FETCH_DELAY + 2);
	localparam int WW = $clog2(LOST_TIMEOUT + 1);

	typedef enum logic [2:0] {
		ST_IDLE,       // also waits for the host on drq
		ST_WAIT_ACK,
		ST_WAIT_READ,
		ST_NEXT_ADDR,
		ST_FETCH,
		ST_FETCH_WAIT,
		ST_RESET
	} state_e;

	state_e        state;
	logic [CW-1:0] count;     // bytes left, current one included
	logic [TW-1:0] timer;     // buffer fetch delay
	logic [WW-1:0] wdog;      // cycles drq has waited
	logic          multi;
	logic          byte_done; // byte read by host or given up
	logic          lost;
	logic          last;
	logic          more;      // another sector follows on this track

	assign byte_done   = state == ST_IDLE && flags.drq
	                     && (data_rd || wdog == WW'(LOST_TIMEOUT - 1));
	assign lost        = byte_done && !data_rd;
	assign last        = count == CW'(1);
	assign more        = multi && wh_req.sector < 8'(SECTORS_PER_TRACK);
	assign next_sector = wh_req.sector;

	// lost-data watchdog
	always_ff @(posedge clk or posedge cock) begin
		if (cock)
			wdog <= '0;
		else if (!flags.drq || data_rd)
			wdog <= '0;
		else
			wdog <= wdog + 1'b1;
	end

	always_ff @(posedge clk or posedge cock) begin
		if (cock) begin
			state       <= ST_IDLE;
			wh_req      <= '{kind: REQ_ACK, default: '0};
			flags       <= '0;
			buff_rd     <= 1'b0;
			buff_addr   <= '0;
			count       <= '0;
			timer       <= '0;
			multi       <= 1'b0;
			sector_load <= 1'b0;
		end else begin
			sector_load <= 1'b0;
			if (xfer_cmd.valid && xfer_cmd.op == XFER_ABORT) begin
				state <= ST_RESET;
			end else if (xfer_cmd.valid) begin
				// --------------------------------------------------
				// command start
				flags         <= '{busy: 1'b1, default: 1'b0};
				wh_req.side   <= xfer_cmd.side;
				wh_req.drive  <= xfer_cmd.drive;
				wh_req.sector <= xfer_cmd.sector;
				multi         <= xfer_cmd.multi;
				case (xfer_cmd.op)
				XFER_NOP_WAIT: begin
					wh_req.kind <= REQ_NOP;
					state       <= ST_WAIT_ACK;
				end
				XFER_READ: begin
					wh_req.kind <= REQ_READ;
					count       <= CW'(SECTOR_BYTES);
					state       <= ST_WAIT_READ;
				end
				default: begin
					wh_req.kind <= REQ_READ_ADDR;
					count       <= CW'(6); // id field
					state       <= ST_WAIT_READ;
				end
				endcase
			end else begin
				case (state)
				ST_WAIT_ACK: if (wh_done) begin
					wh_req.kind <= REQ_ACK;
					flags.busy  <= 1'b0;
					flags.irq   <= 1'b1;
					state       <= ST_IDLE;
				end
				ST_WAIT_READ: if (wh_done) begin
					wh_req.kind <= REQ_ACK;
					if (wh_ok) begin
						buff_addr <= '0;
						state     <= ST_FETCH;
					end else begin
						flags.seek_err <= 1'b1; // sector not found
						flags.busy     <= 1'b0;
						flags.irq      <= 1'b1;
						state          <= ST_IDLE;
					end
				end
				ST_NEXT_ADDR: begin
					buff_addr <= buff_addr + 1'b1;
					count     <= count - 1'b1;
					state     <= ST_FETCH;
				end
				ST_FETCH: begin
					buff_rd <= 1'b1;
					timer   <= TW'(FETCH_DELAY);
					state   <= ST_FETCH_WAIT;
				end
				ST_FETCH_WAIT: begin
					if (timer != '0) begin
						timer <= timer - 1'b1;
					end else begin
						buff_rd   <= 1'b0;
						flags.drq <= 1'b1; // byte in data_reg
						state     <= ST_IDLE;
					end
				end
				ST_RESET: begin
					flags.busy  <= 1'b0;
					flags.drq   <= 1'b0;
					buff_rd     <= 1'b0;
					wh_req.kind <= REQ_ACK;
					state       <= ST_IDLE;
				end
				default: if (byte_done) begin
					flags.drq <= 1'b0;
					if (lost)
						flags.lost_data <= 1'b1; // sticky till next command
					if (!last) begin
						state <= ST_NEXT_ADDR;
					end else if (more) begin
						wh_req.kind   <= REQ_READ;
						wh_req.sector <= wh_req.sector + 8'd1;
						sector_load   <= 1'b1;
						count         <= CW'(SECTOR_BYTES);
						state         <= ST_WAIT_READ;
					end else begin
						flags.busy <= 1'b0;
						flags.irq  <= 1'b1;
					end
				end
				endcase
			end
		end
	end

	always_ff @(posedge clk) begin
		if (state == ST_FETCH_WAIT && timer == '0)
			data_reg <= buff_idata;
	end

	a_drq_busy: assert property (@(posedge clk) disable iff (cock)
		flags.drq |-> flags.busy);
	a_addr_range: assert property (@(posedge clk) disable iff (cock)
		int'(buff_addr) < SECTOR_BYTES);
	a_ack_idle: assert property (@(posedge clk) disable iff (cock)
		!flags.busy |-> wh_req.kind == REQ_ACK);

endmodule

// ==== src/fdc_read_port.sv ====
module fdc_read_port import fdc_pkg::*; #(
	parameter int NUM_DRIVES = 2
) (
	input  logic             clk,
	input  logic             cock,
	input  drive_state_t     drives [NUM_DRIVES],
	input  logic [DRV_W-1:0] drive,
	input  logic             cmd_mode,
	input  logic             rd,
	input  fdc_addr_e        rd_sel,
	input  logic [7:0]       track_reg,
	input  logic [7:0]       sector_reg,
	input  logic             side,
	input  logic [7:0]       data_reg,    // last fetched byte
	input  logic [7:0]       data_wr_val, // last host write
	input  xfer_flags_t      flags,
	output logic [7:0]       odata,
	output logic [7:0]       sel_track,
	output logic             irq,
	output logic             drq
);

	drive_state_t cur;
	fdc_status_u  status;
	fdc_status_u  status_q; // taken at the read strobe
	logic [7:0]   data_q;
	logic         not_ready;

	assign not_ready = int'(drive) >= NUM_DRIVES;
	assign sel_track = cur.track;
	assign irq       = flags.irq;
	assign drq       = flags.drq;

	always_comb begin
		cur = '{track: 8'hff, default: 1'b0}; // missing drive
		for (int i = 0; i < NUM_DRIVES; i++) begin
			if (drive == DRV_W'(i))
				cur = drives[i];
		end
	end

	// --------------------------------------------------
	// status byte in the layout of the last command
	always_comb begin
		status = '0; // read_only, crc, write_fault never set
		if (cmd_mode) begin
			status.t2.not_ready = not_ready;
			status.t2.seek_err  = flags.seek_err;
			status.t2.lost_data = flags.lost_data;
			status.t2.drq       = flags.drq;
			status.t2.busy      = flags.busy;
		end else begin
			status.t1.not_ready   = not_ready;
			status.t1.head_loaded = cur.head_loaded;
			status.t1.seek_err    = flags.seek_err;
			status.t1.track0      = cur.track0;
			status.t1.index       = cur.index;
			status.t1.busy        = flags.busy;
		end
	end

	always_ff @(posedge clk or posedge cock) begin
		if (cock)
			status_q <= '0;
		else if (rd)
			status_q <= status;
	end

	always_ff @(posedge clk) begin
		if (rd)
			data_q <= (cmd_mode && flags.busy) ? data_reg : data_wr_val;
	end

	always_comb begin
		case (rd_sel)
		A_CMD:    odata = status_q;
		A_TRACK:  odata = track_reg;
		A_SECTOR: odata = sector_reg;
		A_DATA:   odata = data_q;
		A_CTL2:   odata = {{(7 - DRV_W){1'b1}}, side, drive};
		default:  odata = 8'hff; // unmapped
		endcase
	end

endmodule

// ==== src/fdc_top.sv ====
module fdc_top import fdc_pkg::*; #(
	parameter int NUM_DRIVES        = 2,
	parameter int SECTOR_BYTES      = 1024,
	parameter int SECTORS_PER_TRACK = 5,
	parameter int FETCH_DELAY       = 15,
	parameter int LOST_TIMEOUT      = 255,
	localparam int AW = $clog2(SECTOR_BYTES)
) (
	input  logic          clk,
	input  logic          cock,
	// host side
	input  logic          rd,
	input  logic          wr,
	input  fdc_addr_e     addr,
	input  logic [7:0]    idata,
	output logic [7:0]    odata,
	output logic          irq,
	output logic          drq,
	// sector buffer
	output logic [AW-1:0] buff_addr,
	output logic          buff_rd,
	input  logic [7:0]    buff_idata,
	// workhorse
	output wh_req_t       wh_req,
	input  logic          wh_done,
	input  logic          wh_ok
);

	head_cmd_t        head_cmd;
	xfer_cmd_t        xfer_cmd;
	xfer_flags_t      xfer_flags;
	drive_state_t     drives [NUM_DRIVES];
	fdc_addr_e        rd_sel;
	logic             data_rd;
	logic             side;
	logic             cmd_mode;
	logic             sector_load;
	logic [DRV_W-1:0] drive;
	logic [7:0]       track_reg;
	logic [7:0]       sector_reg;
	logic [7:0]       sel_track;
	logic [7:0]       data_reg;
	logic [7:0]       data_wr_val;
	logic [7:0]       next_sector;

	fdc_host_regs u_regs (
		.clk, .cock, .rd, .wr, .addr, .idata, .xfer_flags, .sel_track,
		.next_sector, .sector_load, .head_cmd, .xfer_cmd, .data_rd,
		.track_reg, .sector_reg, .side, .drive, .cmd_mode, .rd_sel, .data_wr_val
	);

	// one head unit per drive, each matches its own number
	for (genvar i = 0; i < NUM_DRIVES; i++) begin : g_drive
		fdc_drive_head #(.DRIVE_ID(i)) u_head (
			.clk, .cock, .head_cmd, .state(drives[i])
		);
	end

	fdc_transfer #(
		.SECTOR_BYTES      (SECTOR_BYTES),
		.SECTORS_PER_TRACK (SECTORS_PER_TRACK),
		.FETCH_DELAY       (FETCH_DELAY),
		.LOST_TIMEOUT      (LOST_TIMEOUT)
	) u_xfer (
		.clk, .cock, .xfer_cmd, .data_rd, .wh_done, .wh_ok, .buff_idata,
		.wh_req, .buff_addr, .buff_rd, .data_reg, .flags(xfer_flags),
		.next_sector, .sector_load
	);

	fdc_read_port #(.NUM_DRIVES(NUM_DRIVES)) u_port (
		.clk, .cock, .drives, .drive, .cmd_mode, .rd, .rd_sel, .track_reg,
		.sector_reg, .side, .data_reg, .data_wr_val, .flags(xfer_flags),
		.odata, .sel_track, .irq, .drq
	);

endmodule

// ==== tests/fdc_workhorse_model.sv ====
module fdc_workhorse_model import fdc_pkg::*; #(
	parameter int SECTOR_BYTES = 16,
	localparam int AW = $clog2(SECTOR_BYTES)
) (
	input  logic          clk,
	input  logic          cock,
	input  wh_req_t       wh_req,
	output logic          wh_done,
	output logic          wh_ok,
	input  logic [AW-1:0] buff_addr,
	input  logic          buff_rd,
	output logic [7:0]    buff_idata,
	output logic          stuck       // one cycle pulse, ack never came
);

	logic [7:0]  mem [SECTOR_BYTES];  // shared sector buffer
	logic [31:0] seed;
	wh_req_t     req;                 // request as first seen
	int          delay;
	int          n;

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1103515245 + 32'd12345;
	endfunction

	// buffer read port, follows buff_addr while buff_rd
	initial begin
		buff_idata = 8'd0;
		forever begin
			@(negedge clk);
			if (buff_rd)
				buff_idata = mem[buff_addr];
		end
	end

	// --------------------------------------------------
	// request service, level style done/ok
	initial begin
		wh_done = 1'b0;
		wh_ok   = 1'b0;
		stuck   = 1'b0;
		seed    = 32'd49;
		for (int i = 0; i < SECTOR_BYTES; i++)
			mem[i] = 8'd0;
		forever begin
			@(negedge clk);
			if (!cock && wh_req.kind != REQ_ACK) begin
				req   = wh_req;
				seed  = lcg_next(seed);
				delay = 4 + int'(seed[18:16]); // 4 to 11 cycles
				repeat (delay) @(negedge clk);
				if (req.kind != REQ_NOP) begin
					for (int i = 0; i < SECTOR_BYTES; i++)
						mem[i] = 8'(req.sector * 16 + i); // sector in high nibble
				end
				wh_ok   = req.kind == REQ_NOP || req.sector != 8'd7; // sector 7 missing
				wh_done = 1'b1;
				n       = 0;
				while (wh_req.kind != REQ_ACK && n < 64) begin
					@(negedge clk);
					n++;
				end
				wh_done = 1'b0;
				if (n >= 64) begin
					stuck = 1'b1;
					@(negedge clk);
					stuck = 1'b0;
				end
			end
		end
	end

endmodule

// ==== tests/tb_fdc.sv ====
module tb_fdc import fdc_pkg::*; ();

	localparam int SECTOR_BYTES = 16;
	localparam int AW           = $clog2(SECTOR_BYTES);
	localparam int LIMIT        = 600; // cycles per wait
	localparam int W_DRQ        = 0;
	localparam int W_DRQ_LOW    = 1;
	localparam int W_IRQ        = 2;
	localparam int W_REQ        = 3;

	// step sequence, drive and command byte
	localparam logic       STEP_DRV [10] = '{1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0,
	                                         1'b1, 1'b1, 1'b0, 1'b1};
	localparam logic [7:0] STEP_CMD [10] = '{8'h58, 8'h48, 8'h58, 8'h68, 8'h38, 8'h78,
	                                         8'h58, 8'h58, 8'h58, 8'h78};

	logic          clk;
	logic          cock;
	logic          rd;
	logic          wr;
	fdc_addr_e     addr;
	logic [7:0]    idata;
	logic [7:0]    odata;
	logic          irq;
	logic          drq;
	logic [AW-1:0] buff_addr;
	logic          buff_rd;
	logic [7:0]    buff_idata;
	wh_req_t       wh_req;
	logic          wh_done;
	logic          wh_ok;
	logic          stuck;

	logic       chk_en;      // odata compare armed
	logic [7:0] chk_val;
	logic [7:0] chk_mask;
	string      chk_name;
	logic       ack_chk;     // after force interrupt
	int         errors   = 0;
	int         timeouts = 0;
	logic [7:0] head_pos [2]; // predicted head per drive
	logic [7:0] trk;          // predicted track register
	logic       dir_out;      // remembered step direction

	fdc_top #(
		.NUM_DRIVES        (2),
		.SECTOR_BYTES      (SECTOR_BYTES),
		.SECTORS_PER_TRACK (3),
		.FETCH_DELAY       (3),
		.LOST_TIMEOUT      (40)
	) i_dut (
		.clk, .cock, .rd, .wr, .addr, .idata, .odata, .irq, .drq,
		.buff_addr, .buff_rd, .buff_idata, .wh_req, .wh_done, .wh_ok
	);

	fdc_workhorse_model #(.SECTOR_BYTES(SECTOR_BYTES)) i_model (
		.clk, .cock, .wh_req, .wh_done, .wh_ok, .buff_addr, .buff_rd, .buff_idata, .stuck
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// --------------------------------------------------
	// checks
	a_read_value: assert property (@(posedge clk) disable iff (cock)
		chk_en |-> (odata & chk_mask) == chk_val)
	else begin
		errors++;
		$display("** Error %0t: %s = %h, expected %h",
			$time, chk_name, odata & chk_mask, chk_val);
	end

	a_drq_idle: assert property (@(posedge clk) disable iff (cock) drq |-> !irq)
	else begin
		errors++;
		$display("drq was high at %0t while no command was running", $time);
	end

	a_force_ack: assert property (@(posedge clk) disable iff (cock)
		ack_chk |-> wh_req.kind == REQ_ACK && !drq)
	else begin
		errors++;
		$display("** Error %0t: wh_req.kind = %0d, drq = %b, expected 0 and 0",
			$time, wh_req.kind, drq);
	end

	a_model_ack: assert property (@(posedge clk) disable iff (cock) !stuck)
	else begin
		timeouts++;
		$display("workhorse model waited too long for ack at %0t", $time);
	end

	// --------------------------------------------------
	// host side tasks
	function automatic logic reached(input int what);
		case (what)
		W_DRQ:     return drq;
		W_DRQ_LOW: return !drq;
		W_IRQ:     return irq;
		default:   return wh_req.kind != REQ_ACK;
		endcase
	endfunction

	task automatic wait_until(input int what, input string name);
		int n;
		n = 0;
		do begin
			@(negedge clk);
			n++;
		end while (!reached(what) && n < LIMIT);
		if (!reached(what)) begin
			timeouts++;
			$display("gave up at %0t waiting for %s", $time, name);
		end
	endtask

	task automatic host_write(input fdc_addr_e a, input logic [7:0] v);
		@(negedge clk);
		wr    = 1'b1;
		addr  = a;
		idata = v;
		@(negedge clk);
		wr = 1'b0;
	endtask

	// odata settles one cycle after rd, compared on the next edge
	task automatic host_read(input fdc_addr_e a, input logic [7:0] v, input logic [7:0] m,
			input string name);
		@(negedge clk);
		rd   = 1'b1;
		addr = a;
		@(negedge clk);
		rd       = 1'b0;
		chk_val  = v & m;
		chk_mask = m;
		chk_name = name;
		chk_en   = 1'b1;
		@(negedge clk);
		chk_en = 1'b0;
	endtask

	task automatic take_bytes(input int sec, input int from, input int upto);
		for (int i = from; i <= upto; i++) begin
			wait_until(W_DRQ, "drq");
			host_read(A_DATA, 8'(sec * 16 + i), 8'hff, "data");
		end
	endtask

	task automatic step_drive(input logic d, input logic [7:0] cmd);
		host_write(A_CTL2, {7'd0, d});
		host_write(A_CMD, cmd);
		wait_until(W_IRQ, "irq after step");
		if (cmd[6])
			dir_out = cmd[5];   // step-in or step-out sets direction
		head_pos[d] = dir_out ? head_pos[d] - 8'd1 : head_pos[d] + 8'd1;
		if (cmd[4])
			trk = head_pos[d];  // update variant only
		host_read(A_TRACK, trk, 8'hff, "track");
		host_read(A_CMD, {5'b00100, head_pos[d] == 8'd0, 2'b00}, 8'h24, "status track0");
	endtask

	task automatic force_int();
		host_write(A_CMD, 8'hd0);
		repeat (2) @(negedge clk); // ack two cycles after the write edge
		ack_chk = 1'b1;
		@(negedge clk);
		ack_chk = 1'b0;
	endtask

	// --------------------------------------------------
	// main sequence
	initial begin
		cock     = 1'b1;
		rd       = 1'b0;
		wr       = 1'b0;
		addr     = A_CMD;
		idata    = 8'd0;
		chk_en   = 1'b0;
		chk_val  = 8'd0;
		chk_mask = 8'd0;
		chk_name = "";
		ack_chk  = 1'b0;
		trk      = 8'd0;
		dir_out  = 1'b0;
		head_pos[0] = 8'hff;
		head_pos[1] = 8'hff;
		repeat (8) @(negedge clk);
		cock = 1'b0;

		// restore, drive 0 with head load, drive 1 without
		host_write(A_CTL2, 8'h00);
		host_write(A_CMD, 8'h08);
		wait_until(W_IRQ, "irq after restore");
		host_read(A_CMD, 8'h24, 8'hb5, "status after restore");
		host_read(A_TRACK, 8'h00, 8'hff, "track");
		host_write(A_CTL2, 8'h01);
		host_write(A_CMD, 8'h00);
		wait_until(W_IRQ, "irq after restore");
		host_read(A_CMD, 8'h04, 8'hb5, "status after restore");
		host_read(A_TRACK, 8'h00, 8'hff, "track");
		head_pos[0] = 8'd0;
		head_pos[1] = 8'd0;

		for (int k = 0; k < 10; k++)
			step_drive(STEP_DRV[k], STEP_CMD[k]);

		// single sector
		host_write(A_SECTOR, 8'd2);
		host_write(A_CMD, 8'h80);
		take_bytes(2, 0, 15);
		wait_until(W_IRQ, "irq after read");
		host_read(A_CMD, 8'h00, 8'h97, "status after read");

		// multi-sector to end of track
		host_write(A_SECTOR, 8'd1);
		host_write(A_CMD, 8'h90);
		for (int s = 1; s <= 3; s++) begin
			wait_until(W_DRQ, "first byte of sector");
			host_read(A_SECTOR, 8'(s), 8'hff, "sector");
			take_bytes(s, 0, 15);
		end
		wait_until(W_IRQ, "irq after multi read");

		// host too slow on byte 5
		host_write(A_SECTOR, 8'd4);
		host_write(A_CMD, 8'h80);
		take_bytes(4, 0, 4);
		wait_until(W_DRQ, "drq of byte 5");
		wait_until(W_DRQ_LOW, "lost data");
		host_read(A_CMD, 8'h05, 8'h05, "status lost_data");
		take_bytes(4, 6, 15);
		wait_until(W_IRQ, "irq after lost data");

		// missing sector
		host_write(A_SECTOR, 8'd7);
		host_write(A_CMD, 8'h80);
		wait_until(W_IRQ, "irq after sector 7");
		host_read(A_CMD, 8'h10, 8'h91, "status seek_err");

		// force interrupt, data phase then request phase
		host_write(A_SECTOR, 8'd0);
		host_write(A_CMD, 8'h80);
		wait_until(W_DRQ, "drq before force");
		force_int();
		host_read(A_CMD, 8'h00, 8'h01, "status busy");
		host_write(A_CMD, 8'h80);
		wait_until(W_REQ, "read request");
		force_int();

		$display("errors: %0d, timeouts: %0d", errors, timeouts);
		if (errors == 0 && timeouts == 0)
			$display("Testbench passed");
		else
			$display("Testbench failed");
		$finish;
	end

endmodule

// ==== compile.f ====
src/fdc_pkg.sv
src/fdc_host_regs.sv
src/fdc_drive_head.sv
src/fdc_transfer.sv
src/fdc_read_port.sv
src/fdc_top.sv
tests/fdc_workhorse_model.sv
tests/tb_fdc.sv

// ==== Makefile ====
.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module tb_fdc -f compile.f
	out="$$(./obj_dir/Vtb_fdc)"; echo "$$out"; echo "$$out" | grep -qx "Testbench passed"

clean:
	rm -rf obj_dir
